//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= sdram_ctrl_tb
FILELIST   ?= filelist.f
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- filelist.f
+incdir+include
hdl/sdram_pkg.sv
hdl/sdram_sequencer.sv
hdl/sdram_cmd_encoder.sv
hdl/sdram_datapath.sv
hdl/sdram_ctrl_top.sv
verification/sdram_model.sv
verification/sdram_ctrl_assert.sv
verification/sdram_ctrl_tb.sv

//--- hdl/sdram_cmd_encoder.sv
// SDRAM command encoder
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_cmd_encoder (
    input  sdram_pkg::seq_state_e state,
    input  sdram_pkg::host_req_t  lat_req,
    output sdram_pkg::sdram_bus_t sdram
);

    logic [`SDRAM_BA_W-1:0]  bank;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_COL_W-1:0] col;
    logic [`SDRAM_ROW_W-1:0] col_word;
    logic [`SDRAM_ROW_W-1:0] ap_word;

    assign bank = lat_req.addr[`SDRAM_BANK_LSB +: `SDRAM_BA_W];
    assign row  = lat_req.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
    assign col  = lat_req.addr[`SDRAM_COL_W-1:0];

    // Column plus auto-precharge, upper pins held at zero
    always_comb begin
        col_word = '0;
        col_word[`SDRAM_COL_W-1:0] = col;
        col_word[`SDRAM_AP_BIT] = 1'b1;
    end

    always_comb begin
        ap_word = '0;
        ap_word[`SDRAM_AP_BIT] = 1'b1;
    end

    always_comb begin
        sdram.cmd  = sdram_pkg::CMD_NOP;
        sdram.ba   = '0;
        sdram.addr = '0;
        sdram.dqm  = 1'b1;

        case (state)
            sdram_pkg::RESET_PRECHARGE: begin
                sdram.cmd  = sdram_pkg::CMD_PRECHARGE;
                sdram.addr = ap_word;
            end
            sdram_pkg::RESET_REF0,
            sdram_pkg::RESET_REF1,
            sdram_pkg::REFRESH_AUTO: begin
                sdram.cmd = sdram_pkg::CMD_REFRESH;
            end
            sdram_pkg::RESET_LOAD: begin
                sdram.cmd  = sdram_pkg::CMD_LOAD_MODE;
                sdram.addr = `SDRAM_MODE_VALUE;
            end
            sdram_pkg::READ_ACTIVE,
            sdram_pkg::WRITE_ACTIVE: begin
                sdram.cmd  = sdram_pkg::CMD_ACTIVE;
                sdram.ba   = bank;
                sdram.addr = row;
                sdram.dqm  = 1'b0;
            end
            sdram_pkg::READ_CMD: begin
                sdram.cmd  = sdram_pkg::CMD_READ;
                sdram.ba   = bank;
                sdram.addr = col_word;
                sdram.dqm  = 1'b0;
            end
            sdram_pkg::WRITE_CMD: begin
                sdram.cmd  = sdram_pkg::CMD_WRITE;
                sdram.ba   = bank;
                sdram.addr = col_word;
                sdram.dqm  = 1'b0;
            end
            // Bytes stay enabled across the rest of an access
            sdram_pkg::READ_INITIAL,
            sdram_pkg::READ_NOP,
            sdram_pkg::READ_DATA,
            sdram_pkg::WRITE_INITIAL,
            sdram_pkg::WRITE_NOP: begin
                sdram.dqm = 1'b0;
            end
            default: begin
                sdram.cmd = sdram_pkg::CMD_NOP;
            end
        endcase
    end

endmodule

//--- hdl/sdram_ctrl_top.sv
// SDRAM controller top level
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  sdram_pkg::host_req_t      req,
    output logic                      ready,
    output logic                      done,
    output logic [`SDRAM_DATA_W-1:0]  rd_data,
    output sdram_pkg::sdram_bus_t     sdram,
    output logic [`SDRAM_DATA_W-1:0]  dq_out,
    output logic                      dq_oe,
    input  logic [`SDRAM_DATA_W-1:0]  dq_in
);

    sdram_pkg::seq_state_e state;
    sdram_pkg::host_req_t  lat_req;
    logic                  accept;

    sdram_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .op        (req.op),
        .state     (state),
        .accept    (accept),
        .ready     (ready),
        .done      (done)
    );

    sdram_cmd_encoder u_cmd_encoder (
        .state   (state),
        .lat_req (lat_req),
        .sdram   (sdram)
    );

    sdram_datapath u_datapath (
        .clk     (clk),
        .rst     (rst),
        .accept  (accept),
        .req     (req),
        .state   (state),
        .dq_in   (dq_in),
        .lat_req (lat_req),
        .dq_out  (dq_out),
        .dq_oe   (dq_oe),
        .rd_data (rd_data)
    );

endmodule

//--- hdl/sdram_datapath.sv
// SDRAM request latch and data path
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      accept,
    input  sdram_pkg::host_req_t      req,
    input  sdram_pkg::seq_state_e     state,
    input  logic [`SDRAM_DATA_W-1:0]  dq_in,
    output sdram_pkg::host_req_t      lat_req,
    output logic [`SDRAM_DATA_W-1:0]  dq_out,
    output logic                      dq_oe,
    output logic [`SDRAM_DATA_W-1:0]  rd_data
);

    // Request held for the whole access
    always_ff @(posedge clk) begin
        if (rst) begin
            lat_req <= '0;
        end else if (accept) begin
            lat_req <= req;
        end
    end

    // Write data is on the bus only with the WRITE command
    assign dq_out = lat_req.wdata;
    assign dq_oe  = (state == sdram_pkg::WRITE_CMD);

    // CAS latency 2 puts the read word on dq_in in READ_DATA
    assign rd_data = dq_in;

endmodule

//--- hdl/sdram_pkg.sv
// SDRAM controller types

`include "sdram_consts.svh"

package sdram_pkg;

    typedef enum logic [4:0] {
        RESET_NOP0,
        RESET_PRECHARGE,
        RESET_REF0,
        RESET_NOP1,
        RESET_REF1,
        RESET_NOP2,
        RESET_LOAD,
        RESET_NOP3,
        READ_INITIAL,
        READ_ACTIVE,
        READ_CMD,
        READ_NOP,
        READ_DATA,
        WRITE_INITIAL,
        WRITE_ACTIVE,
        WRITE_CMD,
        WRITE_NOP,
        REFRESH_INITIAL,
        REFRESH_NOP0,
        REFRESH_AUTO,
        REFRESH_NOP1,
        REFRESH_NOP2,
        REFRESH_IDLE,
        IDLE
    } seq_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } sdram_op_e;

    // Pin order is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    typedef struct packed {
        sdram_op_e                 op;
        logic [`SDRAM_ADDR_W-1:0]  addr;
        logic [`SDRAM_DATA_W-1:0]  wdata;
    } host_req_t;

    typedef struct packed {
        sdram_cmd_e                cmd;
        logic [`SDRAM_BA_W-1:0]    ba;
        logic [`SDRAM_ROW_W-1:0]   addr;
        logic                      dqm;
    } sdram_bus_t;

endpackage

//--- hdl/sdram_sequencer.sv
// SDRAM command sequencer
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  sdram_pkg::sdram_op_e  op,
    output sdram_pkg::seq_state_e state,
    output logic                  accept,
    output logic                  ready,
    output logic                  done
);

    localparam int REF_W = $clog2(`SDRAM_REFRESH_IDLE_CYCLES + 1);

    sdram_pkg::seq_state_e next_state;
    logic [REF_W-1:0]      refresh_count;
    logic                  refresh_due;
    logic                  init_wait;

    assign refresh_due = (refresh_count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= sdram_pkg::RESET_NOP0;
            init_wait     <= 1'b1;
            refresh_count <= REF_W'(`SDRAM_REFRESH_IDLE_CYCLES);
        end else begin
            state     <= next_state;
            init_wait <= 1'b0;
            // Count down only while sitting in IDLE
            if (state != sdram_pkg::IDLE) begin
                refresh_count <= REF_W'(`SDRAM_REFRESH_IDLE_CYCLES);
            end else if (!refresh_due) begin
                refresh_count <= refresh_count - 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // Extra power-up NOP before the precharge-all
            sdram_pkg::RESET_NOP0: begin
                next_state = init_wait ? sdram_pkg::RESET_NOP0
                                       : sdram_pkg::RESET_PRECHARGE;
            end
            sdram_pkg::RESET_PRECHARGE: next_state = sdram_pkg::RESET_REF0;
            sdram_pkg::RESET_REF0:      next_state = sdram_pkg::RESET_NOP1;
            sdram_pkg::RESET_NOP1:      next_state = sdram_pkg::RESET_REF1;
            sdram_pkg::RESET_REF1:      next_state = sdram_pkg::RESET_NOP2;
            sdram_pkg::RESET_NOP2:      next_state = sdram_pkg::RESET_LOAD;
            sdram_pkg::RESET_LOAD:      next_state = sdram_pkg::RESET_NOP3;
            sdram_pkg::RESET_NOP3:      next_state = sdram_pkg::IDLE;

            sdram_pkg::READ_INITIAL:    next_state = sdram_pkg::READ_ACTIVE;
            sdram_pkg::READ_ACTIVE:     next_state = sdram_pkg::READ_CMD;
            sdram_pkg::READ_CMD:        next_state = sdram_pkg::READ_NOP;
            sdram_pkg::READ_NOP:        next_state = sdram_pkg::READ_DATA;
            sdram_pkg::READ_DATA:       next_state = sdram_pkg::IDLE;

            sdram_pkg::WRITE_INITIAL:   next_state = sdram_pkg::WRITE_ACTIVE;
            sdram_pkg::WRITE_ACTIVE:    next_state = sdram_pkg::WRITE_CMD;
            sdram_pkg::WRITE_CMD:       next_state = sdram_pkg::WRITE_NOP;
            sdram_pkg::WRITE_NOP:       next_state = sdram_pkg::IDLE;

            sdram_pkg::REFRESH_INITIAL: next_state = sdram_pkg::REFRESH_NOP0;
            sdram_pkg::REFRESH_NOP0:    next_state = sdram_pkg::REFRESH_AUTO;
            sdram_pkg::REFRESH_AUTO:    next_state = sdram_pkg::REFRESH_NOP1;
            sdram_pkg::REFRESH_NOP1:    next_state = sdram_pkg::REFRESH_NOP2;
            sdram_pkg::REFRESH_NOP2:    next_state = sdram_pkg::REFRESH_IDLE;
            sdram_pkg::REFRESH_IDLE:    next_state = sdram_pkg::IDLE;

            // Host request wins over a due refresh
            sdram_pkg::IDLE: begin
                if (req_valid) begin
                    if (op == sdram_pkg::OP_WRITE) begin
                        next_state = sdram_pkg::WRITE_INITIAL;
                    end else begin
                        next_state = sdram_pkg::READ_INITIAL;
                    end
                end else if (refresh_due) begin
                    next_state = sdram_pkg::REFRESH_INITIAL;
                end
            end

            default: next_state = sdram_pkg::RESET_NOP0;
        endcase
    end

    assign ready  = (state == sdram_pkg::IDLE);
    assign accept = req_valid && (state == sdram_pkg::IDLE);
    assign done   = (state == sdram_pkg::READ_DATA) || (state == sdram_pkg::WRITE_NOP);

endmodule

//--- include/sdram_consts.svh
// SDRAM controller constants
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// Bus widths
`define SDRAM_ADDR_W 25
`define SDRAM_DATA_W 16
`define SDRAM_ROW_W 13
`define SDRAM_BA_W 2
`define SDRAM_COL_W 10

// Host address layout is {bank, row, column}
`define SDRAM_BANK_LSB 23
`define SDRAM_ROW_LSB 10

// A10 selects auto-precharge on column commands, all banks on PRECHARGE
`define SDRAM_AP_BIT 10

// Single-location write, CAS latency 2, burst length 1
`define SDRAM_MODE_VALUE 13'b0_0010_0010_1000

// Idle cycles between auto-refreshes
`define SDRAM_REFRESH_IDLE_CYCLES 32

`define SDRAM_CAS_LATENCY 2

`endif

//--- verification/sdram_ctrl_assert.sv
// Handshake and command checks
`timescale 1ns/100ps

module sdram_ctrl_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  req_valid,
    input logic                  ready,
    input logic                  done,
    input logic                  dq_oe,
    input sdram_pkg::sdram_bus_t sdram
);

    req_only_when_ready: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> ready)
        else $error("request strobe while ready is low");

    oe_only_on_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> (sdram.cmd == sdram_pkg::CMD_WRITE))
        else $error("dq_oe without a WRITE command");

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind sdram_ctrl_top sdram_ctrl_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .ready     (ready),
    .done      (done),
    .dq_oe     (dq_oe),
    .sdram     (sdram)
);

//--- verification/sdram_ctrl_tb.sv
// SDRAM controller testbench
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_ctrl_tb;

    localparam int TABLE_LEN = 20;
    localparam int LIMIT = TABLE_LEN * 50 + 100 + 400;

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    sdram_pkg::host_req_t     req;
    logic                     ready;
    logic                     done;
    logic [`SDRAM_DATA_W-1:0] rd_data;
    sdram_pkg::sdram_bus_t    sdram;
    logic [`SDRAM_DATA_W-1:0] dq_out;
    logic                     dq_oe;
    logic [`SDRAM_DATA_W-1:0] dq_in;

    sdram_pkg::sdram_op_e     op_tab [TABLE_LEN];
    logic [`SDRAM_ADDR_W-1:0] addr_tab [TABLE_LEN];
    logic [`SDRAM_DATA_W-1:0] wdata_tab [TABLE_LEN];
    logic [`SDRAM_DATA_W-1:0] exp_mem [logic [`SDRAM_ADDR_W-1:0]];
    sdram_pkg::sdram_cmd_e    init_cmds [9];

    logic [31:0] seed;
    int          err_count;
    int          test_count;
    int          cycles;

    sdram_ctrl_top uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .done      (done),
        .rd_data   (rd_data),
        .sdram     (sdram),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    sdram_model u_model (
        .clk    (clk),
        .sdram  (sdram),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_data(input string name, input logic [`SDRAM_DATA_W-1:0] got,
                              input logic [`SDRAM_DATA_W-1:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_e got,
                             input sdram_pkg::sdram_cmd_e exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bus(input string name, input sdram_pkg::sdram_bus_t got,
                             input sdram_pkg::sdram_bus_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Column command word is {zeros, A10, column}
    function automatic sdram_pkg::sdram_bus_t col_bus(input sdram_pkg::sdram_cmd_e cmd,
                                                      input logic [24:0] a);
        sdram_pkg::sdram_bus_t b;
        b.cmd  = cmd;
        b.ba   = a[24:23];
        b.addr = {2'b00, 1'b1, a[9:0]};
        b.dqm  = 1'b0;
        return b;
    endfunction

    task automatic run_access(input sdram_pkg::sdram_op_e op, input logic [24:0] addr,
                              input logic [15:0] wdata, input bit at_due);
        int                    n;
        int                    errs_before;
        bit                    got_done;
        logic                  exp_oe;
        sdram_pkg::sdram_bus_t act;
        logic [15:0]           exp_data;
        errs_before = err_count;
        act.cmd  = sdram_pkg::CMD_ACTIVE;
        act.ba   = addr[24:23];
        act.addr = addr[22:10];
        act.dqm  = 1'b0;
        // Wait for IDLE without a refresh firing on the strobe edge
        do begin
            @(negedge clk);
        end while (!(ready && (at_due ? (uut.u_sequencer.refresh_count == 1)
                                      : (uut.u_sequencer.refresh_count != 0))));
        @(posedge clk);
        req_valid <= 1'b1;
        req.op    <= op;
        req.addr  <= addr;
        req.wdata <= wdata;
        @(posedge clk);
        req_valid <= 1'b0;
        n = 0;
        got_done = 1'b0;
        while (!got_done && n < 20) begin
            @(negedge clk);
            n++;
            exp_oe = (op == sdram_pkg::OP_WRITE) && (n == 3);
            check_data("dq_oe", 16'(dq_oe), 16'(exp_oe));
            if (n == 2) begin
                check_bus("sdram active", sdram, act);
            end
            if (n == 3) begin
                check_bus("sdram column", sdram,
                          col_bus(op == sdram_pkg::OP_WRITE ? sdram_pkg::CMD_WRITE
                                                            : sdram_pkg::CMD_READ, addr));
                if (op == sdram_pkg::OP_WRITE) begin
                    check_data("dq_out", dq_out, wdata);
                end
            end
            if (done) begin
                got_done = 1'b1;
                if (op == sdram_pkg::OP_READ) begin
                    exp_data = exp_mem.exists(addr) ? exp_mem[addr] : 16'h0;
                    check_data("rd_data", rd_data, exp_data);
                    if (n != 5) begin
                        err_count++;
                        $display("Read done came %0d cycles after accept, not 5", n);
                    end
                end else if (n != 4) begin
                    err_count++;
                    $display("Write done came %0d cycles after accept, not 4", n);
                end
            end
        end
        if (!got_done) begin
            err_count++;
            $display("No done pulse within 20 cycles of the request");
        end
        if (op == sdram_pkg::OP_WRITE) begin
            exp_mem[addr] = wdata;
        end
        test_count++;
        $display("test %0d %s addr %h: %s", test_count,
                 op == sdram_pkg::OP_WRITE ? "write" : "read", addr,
                 err_count == errs_before ? "ok" : "failed");
    endtask

    task automatic check_init();
        sdram_pkg::sdram_bus_t idle_bus;
        idle_bus = '{cmd: sdram_pkg::CMD_NOP, ba: '0, addr: '0, dqm: 1'b1};
        for (int i = 0; i < 9; i++) begin
            @(negedge clk);
            check_cmd("init cmd", sdram.cmd, init_cmds[i]);
            check_data("init ready", 16'(ready), 16'h0);
            if (init_cmds[i] == sdram_pkg::CMD_PRECHARGE) begin
                check_data("precharge a10", 16'(sdram.addr[10]), 16'h1);
            end
            if (init_cmds[i] == sdram_pkg::CMD_LOAD_MODE) begin
                check_data("mode word", 16'(sdram.addr), 16'(`SDRAM_MODE_VALUE));
            end
            if (i < 2) begin
                check_bus("init nop", sdram, idle_bus);
            end
        end
        @(negedge clk);
        check_data("ready after init", 16'(ready), 16'h1);
        test_count++;
        $display("test %0d init sequence: %s", test_count, err_count == 0 ? "ok" : "failed");
    endtask

    task automatic idle_refresh_check();
        int idle_run;
        int refreshes;
        int errs_before;
        errs_before = err_count;
        idle_run = 0;
        refreshes = 0;
        repeat (130) begin
            @(negedge clk);
            if (ready) begin
                idle_run++;
            end else if (sdram.cmd == sdram_pkg::CMD_REFRESH) begin
                refreshes++;
                if (idle_run < `SDRAM_REFRESH_IDLE_CYCLES ||
                    idle_run > `SDRAM_REFRESH_IDLE_CYCLES + 1) begin
                    err_count++;
                    $display("Refresh came after %0d idle cycles", idle_run);
                end
                idle_run = 0;
            end
        end
        if (refreshes < 2) begin
            err_count++;
            $display("Only %0d refreshes seen during the idle stretch", refreshes);
        end
        test_count++;
        $display("test %0d idle refresh: %s", test_count,
                 err_count == errs_before ? "ok" : "failed");
    endtask

    initial begin
        sdram_pkg::sdram_bus_t rst_bus;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        err_count = 0;
        test_count = 0;
        cycles = 0;
        seed = 32'h97ee;
        rst_bus = '{cmd: sdram_pkg::CMD_NOP, ba: '0, addr: '0, dqm: 1'b1};
        init_cmds = '{sdram_pkg::CMD_NOP, sdram_pkg::CMD_NOP, sdram_pkg::CMD_PRECHARGE,
                      sdram_pkg::CMD_REFRESH, sdram_pkg::CMD_NOP, sdram_pkg::CMD_REFRESH,
                      sdram_pkg::CMD_NOP, sdram_pkg::CMD_LOAD_MODE, sdram_pkg::CMD_NOP};
        // Corner addresses, then random writes, then read back every one
        addr_tab[0] = 25'h0;
        addr_tab[1] = 25'h1ffffff;
        addr_tab[2] = {2'b11, 13'h0000, 10'h3ff};
        addr_tab[3] = {2'b00, 13'h1fff, 10'h000};
        for (int i = 0; i < TABLE_LEN / 2; i++) begin
            seed = lcg_next(seed);
            if (i >= 4) begin
                addr_tab[i] = seed[24:0];
            end
            seed = lcg_next(seed);
            wdata_tab[i] = seed[31:16];
            op_tab[i] = sdram_pkg::OP_WRITE;
            op_tab[i + TABLE_LEN / 2] = sdram_pkg::OP_READ;
            addr_tab[i + TABLE_LEN / 2] = addr_tab[i];
            wdata_tab[i + TABLE_LEN / 2] = '0;
        end

        repeat (7) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_bus("reset bus", sdram, rst_bus);
        check_data("reset ready", 16'({ready, done, dq_oe}), 16'h0);
        @(posedge clk);
        rst <= 1'b0;
        check_init();

        for (int i = 0; i < TABLE_LEN; i++) begin
            run_access(op_tab[i], addr_tab[i], wdata_tab[i], 1'b0);
        end

        idle_refresh_check();
        run_access(sdram_pkg::OP_READ, addr_tab[4], '0, 1'b1);
        run_access(sdram_pkg::OP_READ, addr_tab[1], '0, 1'b0);

        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verification/sdram_model.sv
// Behavioral SDRAM model
`timescale 1ns/100ps

`include "sdram_consts.svh"

module sdram_model (
    input  logic                      clk,
    input  sdram_pkg::sdram_bus_t     sdram,
    input  logic [`SDRAM_DATA_W-1:0]  dq_out,
    input  logic                      dq_oe,
    output logic [`SDRAM_DATA_W-1:0]  dq_in
);

    localparam int KEY_W = `SDRAM_BA_W + `SDRAM_ROW_W + `SDRAM_COL_W;

    logic [`SDRAM_DATA_W-1:0] mem [logic [KEY_W-1:0]];
    logic [`SDRAM_ROW_W-1:0]  open_row [4];
    logic [`SDRAM_DATA_W-1:0] cas_data;
    logic [KEY_W-1:0]         key;

    // Contents of a location never written
    function automatic logic [`SDRAM_DATA_W-1:0] fill_word(input logic [KEY_W-1:0] k);
        return k[15:0] ^ {7'h0, k[24:16]};
    endfunction

    assign key = {sdram.ba, open_row[sdram.ba], sdram.addr[`SDRAM_COL_W-1:0]};

    initial begin
        dq_in    = '0;
        cas_data = '0;
        for (int i = 0; i < 4; i++) begin
            open_row[i] = '0;
        end
    end

    always @(posedge clk) begin
        // Second stage of the CAS latency pipeline
        dq_in <= cas_data;
        case (sdram.cmd)
            sdram_pkg::CMD_ACTIVE: begin
                open_row[sdram.ba] <= sdram.addr;
            end
            sdram_pkg::CMD_WRITE: begin
                if (dq_oe) begin
                    mem[key] = dq_out;
                end
            end
            sdram_pkg::CMD_READ: begin
                if (mem.exists(key)) begin
                    cas_data <= mem[key];
                end else begin
                    cas_data <= fill_word(key);
                end
            end
            default: begin
            end
        endcase
    end

endmodule
